// File: csrPkg.sv
//////////////////////////////////////////////////////////////////////
// CSR shared definitions
//////////////////////////////////////////////////////////////////////

package csrPkg;

  // Data width of the core
  localparam int xlen = 32;

  // Privilege encodings, only U and M are implemented
  localparam logic [1:0] privU = 2'b00;
  localparam logic [1:0] privM = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////

  // Machine information, trap setup and trap handling
  localparam logic [11:0] adrMstatus       = 12'h300;
  localparam logic [11:0] adrMisa          = 12'h301;
  localparam logic [11:0] adrMtvec         = 12'h305;
  localparam logic [11:0] adrMcountinhibit = 12'h320;
  localparam logic [11:0] adrMscratch      = 12'h340;
  localparam logic [11:0] adrMepc          = 12'h341;
  localparam logic [11:0] adrMcause        = 12'h342;
  localparam logic [11:0] adrMtval         = 12'h343;
  localparam logic [11:0] adrMhartid       = 12'hF14;

  // Machine counters, low and high halves
  localparam logic [11:0] adrMcycle        = 12'hB00;
  localparam logic [11:0] adrMinstret      = 12'hB02;
  localparam logic [11:0] adrMcycleh       = 12'hB80;
  localparam logic [11:0] adrMinstreth     = 12'hB82;

  // User floating-point status
  localparam logic [11:0] adrFflags        = 12'h001;
  localparam logic [11:0] adrFrm           = 12'h002;
  localparam logic [11:0] adrFcsr          = 12'h003;

  // MXL = 1 for RV32, extensions I, M, F and U
  localparam logic [xlen-1:0] misaValue   = 32'h4010_1120;
  localparam logic [xlen-1:0] hartIdValue = '0;

  // Instruction fields used by the CSR datapath
  localparam int opLsb     = 12;
  localparam int opMsb     = 13;
  localparam int immSelBit = 14;
  localparam int rs1Lsb    = 15;
  localparam int rs1Msb    = 19;
  localparam int adrLsb    = 20;
  localparam int adrMsb    = 31;

  // mstatus seen as one word or as its implemented fields
  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic [18:0] rsvdHigh;
      logic [1:0]  mpp;
      logic [2:0]  rsvdMid;
      logic        mpie;
      logic [2:0]  rsvdLow;
      logic        mie;
      logic [2:0]  rsvdBase;
    } f;
  } mstatusWordT;

endpackage

// File: csrStatus.sv
//////////////////////////////////////////////////////////////////////
// mstatus and privilege mode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrStatus
  import csrPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [11:0]     adr,
  input  logic [xlen-1:0] writeVal,
  input  logic            writeM,
  input  logic            trap,
  input  logic            mret,
  output logic [1:0]      privilege,
  output mstatusWordT     mstatus,
  output logic [xlen-1:0] readVal,
  output logic            legal
);

  mstatusWordT wrWord;
  logic        wrStatus;
  logic [1:0]  wrMpp;

  assign legal    = (adr == adrMstatus);
  assign wrStatus = writeM & legal;

  // Incoming software word, decoded by field
  always_comb begin
    wrWord.raw = writeVal;
  end

  // MPP is WARL, anything but M falls back to U
  assign wrMpp = (wrWord.f.mpp == privM) ? privM : privU;

  //////////////////////////////////////////////////////////////////////
  // Status update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatus.raw <= '0;
      privilege   <= privM;
    end else if (trap) begin
      // Stack the enable and the old mode
      mstatus.f.mpie <= mstatus.f.mie;
      mstatus.f.mie  <= 1'b0;
      mstatus.f.mpp  <= privilege;
      privilege      <= privM;
    end else if (mret) begin
      // Pop the stack, MPP drops to least privilege
      mstatus.f.mie  <= mstatus.f.mpie;
      mstatus.f.mpie <= 1'b1;
      mstatus.f.mpp  <= privU;
      privilege      <= mstatus.f.mpp;
    end else if (wrStatus) begin
      // Only implemented fields take the write
      mstatus.f.mie  <= wrWord.f.mie;
      mstatus.f.mpie <= wrWord.f.mpie;
      mstatus.f.mpp  <= wrMpp;
    end
  end

  // Reserved bits stay zero from reset
  assign readVal = legal ? mstatus.raw : '0;

endmodule

// File: csrMachine.sv
//////////////////////////////////////////////////////////////////////
// Machine trap and identity registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrMachine
  import csrPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [11:0]     adr,
  input  logic [xlen-1:0] writeVal,
  input  logic            writeM,
  input  logic            trap,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] cause,
  input  logic [xlen-1:0] tval,
  output logic [xlen-1:0] mtvec,
  output logic [xlen-1:0] mepc,
  output logic [xlen-1:0] mcountinhibit,
  output logic [xlen-1:0] readVal,
  output logic            legal
);

  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] mscratch;
  logic            wrMepc;
  logic            wrMcause;
  logic            wrMtval;

  assign wrMepc   = writeM & (adr == adrMepc);
  assign wrMcause = writeM & (adr == adrMcause);
  assign wrMtval  = writeM & (adr == adrMtval);

  //////////////////////////////////////////////////////////////////////
  // Software-only registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvec         <= '0;
      mscratch      <= '0;
      mcountinhibit <= '0;
    end else if (writeM) begin
      case (adr)
        // Direct mode only, base word aligned
        adrMtvec:         mtvec    <= {writeVal[xlen-1:2], 2'b00};
        adrMscratch:      mscratch <= writeVal;
        // CY and IR inhibit bits, TM does not exist
        adrMcountinhibit: mcountinhibit <= {{(xlen-3){1'b0}}, writeVal[2], 1'b0, writeVal[0]};
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trap state
  //////////////////////////////////////////////////////////////////////

  // A trap wins over a software write
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else begin
      // IALIGN 16 view, bit 0 always clear
      if (trap) begin
        mepc <= {pc[xlen-1:1], 1'b0};
      end else if (wrMepc) begin
        mepc <= {writeVal[xlen-1:1], 1'b0};
      end
      if (trap) begin
        mcause <= cause;
      end else if (wrMcause) begin
        mcause <= writeVal;
      end
      if (trap) begin
        mtval <= tval;
      end else if (wrMtval) begin
        mtval <= writeVal;
      end
    end
  end

  // Read mux and address claim
  always_comb begin
    legal = 1'b1;
    case (adr)
      adrMisa:          readVal = misaValue;
      adrMhartid:       readVal = hartIdValue;
      adrMtvec:         readVal = mtvec;
      adrMscratch:      readVal = mscratch;
      adrMepc:          readVal = mepc;
      adrMcause:        readVal = mcause;
      adrMtval:         readVal = mtval;
      adrMcountinhibit: readVal = mcountinhibit;
      default: begin
        readVal = '0;
        legal   = 1'b0;
      end
    endcase
  end

endmodule

// File: csrCounters.sv
//////////////////////////////////////////////////////////////////////
// Machine cycle and retire counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrCounters
  import csrPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [11:0]     adr,
  input  logic [xlen-1:0] writeVal,
  input  logic            writeM,
  input  logic            retire,
  input  logic [xlen-1:0] mcountinhibit,
  output logic [xlen-1:0] readVal,
  output logic            legal
);

  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic        cycleInc;
  logic        instretInc;

  // Next count, a half write replaces the increment
  function automatic logic [63:0] nextCount(
    input logic [63:0]     count,
    input logic            inc,
    input logic            wrLo,
    input logic            wrHi,
    input logic [xlen-1:0] val
  );
    logic [63:0] next;
    next = count + {63'b0, inc};
    if (wrLo) begin
      next = {count[63:32], val};
    end else if (wrHi) begin
      next = {val, count[31:0]};
    end
    return next;
  endfunction

  // CY and IR inhibit bits
  assign cycleInc   = ~mcountinhibit[0];
  assign instretInc = retire & ~mcountinhibit[2];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle   <= nextCount(mcycle, cycleInc, writeM & (adr == adrMcycle),
                            writeM & (adr == adrMcycleh), writeVal);
      minstret <= nextCount(minstret, instretInc, writeM & (adr == adrMinstret),
                            writeM & (adr == adrMinstreth), writeVal);
    end
  end

  // Half-word read view
  always_comb begin
    legal = 1'b1;
    case (adr)
      adrMcycle:    readVal = mcycle[31:0];
      adrMcycleh:   readVal = mcycle[63:32];
      adrMinstret:  readVal = minstret[31:0];
      adrMinstreth: readVal = minstret[63:32];
      default: begin
        readVal = '0;
        legal   = 1'b0;
      end
    endcase
  end

endmodule

// File: csrFloat.sv
//////////////////////////////////////////////////////////////////////
// Floating-point flags and rounding mode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrFloat
  import csrPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [11:0]     adr,
  input  logic [xlen-1:0] writeVal,
  input  logic            writeU,
  input  logic [4:0]      setFflags,
  input  logic            fpDone,
  output logic [2:0]      frm,
  output logic [xlen-1:0] readVal,
  output logic            legal
);

  logic [4:0] fflags;
  logic       isFcsr;
  logic       wrFflags;
  logic       wrFrm;

  // fcsr covers both fields at once
  assign isFcsr   = (adr == adrFcsr);
  assign wrFflags = writeU & ((adr == adrFflags) | isFcsr);
  assign wrFrm    = writeU & ((adr == adrFrm) | isFcsr);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fflags <= '0;
      frm    <= '0;
    end else begin
      // Sticky flags, software write has priority
      if (wrFflags) begin
        fflags <= writeVal[4:0];
      end else if (fpDone) begin
        fflags <= fflags | setFflags;
      end
      if (wrFrm) begin
        frm <= isFcsr ? writeVal[7:5] : writeVal[2:0];
      end
    end
  end

  assign legal   = (adr == adrFflags) | (adr == adrFrm) | isFcsr;
  assign readVal = (adr == adrFflags) ? {{(xlen-5){1'b0}}, fflags} :
                   (adr == adrFrm)    ? {{(xlen-3){1'b0}}, frm} :
                   isFcsr             ? {{(xlen-8){1'b0}}, frm, fflags} : '0;

endmodule

// File: csr.sv
//////////////////////////////////////////////////////////////////////
// CSR file top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csr
  import csrPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] srcA,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] cause,
  input  logic [xlen-1:0] tval,
  input  logic            csrRead,
  input  logic            csrWrite,
  input  logic            trap,
  input  logic            mret,
  input  logic            retire,
  input  logic [4:0]      setFflags,
  input  logic            fpDone,
  output logic [xlen-1:0] readVal,
  output logic            illegalAccess,
  output logic [1:0]      privilege,
  output logic [xlen-1:0] trapVector,
  output logic [xlen-1:0] returnPc,
  output logic [2:0]      frm
);

  logic [11:0]     adr;
  logic [1:0]      op;
  logic [xlen-1:0] src;
  logic [xlen-1:0] oldVal;
  logic [xlen-1:0] writeVal;
  logic [xlen-1:0] statusRead;
  logic [xlen-1:0] machineRead;
  logic [xlen-1:0] counterRead;
  logic [xlen-1:0] floatRead;
  logic            statusLegal;
  logic            machineLegal;
  logic            counterLegal;
  logic            floatLegal;
  logic            unknownAdr;
  logic            lowPrivilege;
  logic            readOnlyWrite;
  logic            illegalNow;
  logic            writeM;
  logic            writeU;
  logic [xlen-1:0] mcountinhibit;

  //////////////////////////////////////////////////////////////////////
  // Read-modify-write datapath
  //////////////////////////////////////////////////////////////////////

  assign adr = instr[adrMsb:adrLsb];
  assign op  = instr[opMsb:opLsb];

  always_comb begin
    // Register source or zero-extended uimm
    src = instr[immSelBit] ? {{(xlen-5){1'b0}}, instr[rs1Msb:rs1Lsb]} : srcA;
    case (op)
      2'b01:   writeVal = src;
      2'b10:   writeVal = oldVal | src;
      2'b11:   writeVal = oldVal & ~src;
      default: writeVal = oldVal;
    endcase
  end

  // Banks drive zero outside their own addresses
  assign oldVal = statusRead | machineRead | counterRead | floatRead;

  //////////////////////////////////////////////////////////////////////
  // Access check
  //////////////////////////////////////////////////////////////////////

  assign unknownAdr    = ~(statusLegal | machineLegal | counterLegal | floatLegal);
  // Address level above the current mode
  assign lowPrivilege  = adr[9:8] > privilege;
  // misa is fixed here, so it joins the read-only space
  assign readOnlyWrite = csrWrite & ((adr[11:10] == 2'b11) | (adr == adrMisa));
  assign illegalNow    = (csrRead | csrWrite) & (unknownAdr | lowPrivilege | readOnlyWrite);

  // Illegal writes are dropped before they reach a bank
  assign writeU = csrWrite & ~illegalNow;
  assign writeM = writeU & (privilege == privM);

  // Registered read port
  always_ff @(posedge clk) begin
    if (!rstN) begin
      readVal       <= '0;
      illegalAccess <= 1'b0;
    end else begin
      illegalAccess <= illegalNow;
      // Old value, hidden on a refused access
      if (csrRead) begin
        readVal <= illegalNow ? '0 : oldVal;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register banks
  //////////////////////////////////////////////////////////////////////

  csrStatus u_csrStatus (
    .clk, .rstN, .adr, .writeVal, .writeM, .trap, .mret,
    .privilege, .mstatus(), .readVal(statusRead), .legal(statusLegal)
  );

  csrMachine u_csrMachine (
    .clk, .rstN, .adr, .writeVal, .writeM, .trap, .pc, .cause, .tval,
    .mtvec(trapVector), .mepc(returnPc), .mcountinhibit,
    .readVal(machineRead), .legal(machineLegal)
  );

  csrCounters u_csrCounters (
    .clk, .rstN, .adr, .writeVal, .writeM, .retire, .mcountinhibit,
    .readVal(counterRead), .legal(counterLegal)
  );

  csrFloat u_csrFloat (
    .clk, .rstN, .adr, .writeVal, .writeU, .setFflags, .fpDone,
    .frm, .readVal(floatRead), .legal(floatLegal)
  );

endmodule

// File: csr_checker.sv
//////////////////////////////////////////////////////////////////////
// CSR file assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrChecker
  import csrPkg::*;
(
  input logic            clk,
  input logic            rstN,
  input logic            csrRead,
  input logic            csrWrite,
  input logic            trap,
  input logic            illegalAccess,
  input logic [1:0]      privilege,
  input logic [xlen-1:0] mepc
);

  // Number of property failures so far
  int failCount = 0;

  // Registered flag follows an access strobe by one cycle
  illegalAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
    illegalAccess |-> $past(csrRead | csrWrite))
    else begin
      failCount++;
      $error("illegalAccess raised without a CSR access in the previous cycle");
    end

  // Only U and M exist
  privilegeLegal: assert property (@(posedge clk) disable iff (!rstN)
    privilege == privU || privilege == privM)
    else begin
      failCount++;
      $error("privilege holds an unimplemented mode");
    end

  trapToMachine: assert property (@(posedge clk) disable iff (!rstN)
    trap |=> privilege == privM)
    else begin
      failCount++;
      $error("privilege is not M after a trap");
    end

  mepcAligned: assert property (@(posedge clk) disable iff (!rstN)
    mepc[0] == 1'b0)
    else begin
      failCount++;
      $error("mepc bit 0 is set");
    end

endmodule

bind csr csrChecker u_csrChecker (
  .clk, .rstN, .csrRead, .csrWrite, .trap, .illegalAccess, .privilege, .mepc(returnPc)
);

// File: csrTb.sv
//////////////////////////////////////////////////////////////////////
// CSR file testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrTb
  import csrPkg::*;
();

  // Strobe bits of a stimulus entry
  localparam logic [5:0] stRead   = 6'b100000;
  localparam logic [5:0] stWrite  = 6'b010000;
  localparam logic [5:0] stTrap   = 6'b001000;
  localparam logic [5:0] stMret   = 6'b000100;
  localparam logic [5:0] stRetire = 6'b000010;
  localparam logic [5:0] stFp     = 6'b000001;

  // RV32 in MXL, then the U, M, I and F extension bits
  localparam logic [31:0] misaExpect = (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 12) |
                                       (32'd1 << 8) | (32'd1 << 5);

  typedef struct packed {
    logic [3:0]  testId;
    logic [5:0]  strobe;
    logic [31:0] instr;
    logic [31:0] srcA;
    logic [31:0] pc;
    logic [31:0] cause;
    logic [31:0] tval;
    logic [4:0]  flags;
    logic [31:0] expRead;
    logic        expIllegal;
    logic [1:0]  expPriv;
    logic [31:0] expVector;
    logic [31:0] expReturn;
    logic [2:0]  expFrm;
  } entryT;

  logic        clk;
  logic        rstN;
  logic [31:0] instr;
  logic [31:0] srcA;
  logic [31:0] pc;
  logic [31:0] cause;
  logic [31:0] tval;
  logic        csrRead;
  logic        csrWrite;
  logic        trap;
  logic        mret;
  logic        retire;
  logic [4:0]  setFflags;
  logic        fpDone;
  logic [31:0] readVal;
  logic        illegalAccess;
  logic [1:0]  privilege;
  logic [31:0] trapVector;
  logic [31:0] returnPc;
  logic [2:0]  frm;

  entryT stim[$];
  logic [3:0] curTest;
  int seed = 14914;
  int cycleLimit = 100000;
  int cycles;
  int checks;
  int errors;
  int testErrs;
  int testsPassed;
  int testsFailed;
  string testNames [1:6] = '{"read-modify-write", "trap entry", "mret to user mode",
                             "illegal access", "counters", "floating-point registers"};

  // Reference model state
  logic [1:0]  refPriv;
  logic        refMie;
  logic        refMpie;
  logic [1:0]  refMpp;
  logic [31:0] refMtvec;
  logic [31:0] refMscratch;
  logic [31:0] refMepc;
  logic [31:0] refMcause;
  logic [31:0] refMtval;
  logic [31:0] refInhibit;
  logic [63:0] refMcycle;
  logic [63:0] refMinstret;
  logic [4:0]  refFflags;
  logic [2:0]  refFrm;
  logic [31:0] refLastRead;

  csr i_csr (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] currentValue(input logic [11:0] adr);
    case (adr)
      adrMstatus:       return {19'b0, refMpp, 3'b0, refMpie, 3'b0, refMie, 3'b0};
      adrMisa:          return misaExpect;
      adrMtvec:         return refMtvec;
      adrMscratch:      return refMscratch;
      adrMepc:          return refMepc;
      adrMcause:        return refMcause;
      adrMtval:         return refMtval;
      adrMcountinhibit: return refInhibit;
      adrMcycle:        return refMcycle[31:0];
      adrMcycleh:       return refMcycle[63:32];
      adrMinstret:      return refMinstret[31:0];
      adrMinstreth:     return refMinstret[63:32];
      adrFflags:        return {27'b0, refFflags};
      adrFrm:           return {29'b0, refFrm};
      adrFcsr:          return {24'b0, refFrm, refFflags};
      default:          return 32'h0;
    endcase
  endfunction

  // Addresses that some bank implements
  function automatic logic claimed(input logic [11:0] adr);
    return adr inside {adrMstatus, adrMisa, adrMtvec, adrMscratch, adrMepc, adrMcause,
                       adrMtval, adrMcountinhibit, adrMhartid, adrMcycle, adrMcycleh,
                       adrMinstret, adrMinstreth, adrFflags, adrFrm, adrFcsr};
  endfunction

  task automatic storeValue(input logic [11:0] adr, input logic [31:0] v);
    case (adr)
      adrMstatus: begin
        refMie  = v[3];
        refMpie = v[7];
        // Only U and M are valid MPP codes
        refMpp  = (v[12:11] == privM) ? privM : privU;
      end
      adrMtvec:         refMtvec = {v[31:2], 2'b00};
      adrMscratch:      refMscratch = v;
      adrMepc:          refMepc = {v[31:1], 1'b0};
      adrMcause:        refMcause = v;
      adrMtval:         refMtval = v;
      adrMcountinhibit: refInhibit = v & 32'h5;
      adrMcycle:        refMcycle[31:0] = v;
      adrMcycleh:       refMcycle[63:32] = v;
      adrMinstret:      refMinstret[31:0] = v;
      adrMinstreth:     refMinstret[63:32] = v;
      adrFflags:        refFflags = v[4:0];
      adrFrm:           refFrm = v[2:0];
      adrFcsr: begin
        refFflags = v[4:0];
        refFrm    = v[7:5];
      end
      default: ;
    endcase
  endtask

  // One entry is one clock edge, the model steps with it
  task automatic addEntry(input logic [5:0] strobe, input logic [31:0] ins,
                          input logic [31:0] data, input logic [31:0] epc,
                          input logic [31:0] code, input logic [31:0] badVal,
                          input logic [4:0] flags);
    entryT       e;
    logic [11:0] adr;
    logic [31:0] src;
    logic [31:0] old;
    logic [31:0] wv;
    logic        illegal;
    logic        wrote;
    logic        cycInc;
    logic        instInc;
    adr = ins[31:20];
    src = ins[14] ? {27'b0, ins[19:15]} : data;
    old = currentValue(adr);
    // Unknown, too privileged, or a write into read-only space
    illegal = (strobe[5] | strobe[4]) &&
              (!claimed(adr) || adr[9:8] > refPriv ||
               (strobe[4] && (adr[11:10] == 2'b11 || adr == adrMisa)));
    case (ins[13:12])
      2'b01:   wv = src;
      2'b10:   wv = old | src;
      2'b11:   wv = old & ~src;
      default: wv = old;
    endcase
    // Inhibit value before the edge decides the increments
    cycInc  = !refInhibit[0];
    instInc = strobe[1] && !refInhibit[2];
    wrote   = strobe[4] && !illegal;
    if (strobe[5]) begin
      refLastRead = illegal ? 32'h0 : old;
    end
    if (!(wrote && adr inside {adrMcycle, adrMcycleh})) begin
      refMcycle = refMcycle + {63'b0, cycInc};
    end
    if (!(wrote && adr inside {adrMinstret, adrMinstreth})) begin
      refMinstret = refMinstret + {63'b0, instInc};
    end
    if (strobe[0] && !(wrote && adr inside {adrFflags, adrFcsr})) begin
      refFflags = refFflags | flags;
    end
    if (wrote) begin
      storeValue(adr, wv);
    end
    if (strobe[3]) begin
      refMpie   = refMie;
      refMie    = 1'b0;
      refMpp    = refPriv;
      refPriv   = privM;
      refMepc   = {epc[31:1], 1'b0};
      refMcause = code;
      refMtval  = badVal;
    end
    if (strobe[2]) begin
      refMie  = refMpie;
      refMpie = 1'b1;
      refPriv = refMpp;
      refMpp  = privU;
    end
    e = '{curTest, strobe, ins, data, epc, code, badVal, flags, refLastRead,
          illegal, refPriv, refMtvec, refMepc, refFrm};
    stim.push_back(e);
  endtask

  // Immediate forms take the uimm from the low data bits
  task automatic rmw(input logic [11:0] adr, input logic [2:0] f3, input logic [31:0] data);
    addEntry(stRead | stWrite, {adr, data[4:0], f3, 5'd1, 7'h73}, data, 0, 0, 0, 0);
  endtask

  task automatic readCsr(input logic [11:0] adr);
    addEntry(stRead, {adr, 5'd0, 3'b010, 5'd1, 7'h73}, 0, 0, 0, 0, 0);
  endtask

  task automatic writeCsr(input logic [11:0] adr, input logic [31:0] data);
    addEntry(stWrite, {adr, 5'd2, 3'b001, 5'd0, 7'h73}, data, 0, 0, 0, 0);
  endtask

  task automatic raiseTrap(input logic [31:0] epc, input logic [31:0] code,
                           input logic [31:0] badVal);
    addEntry(stTrap, 32'h13, 0, epc, code, badVal, 0);
  endtask

  task automatic returnMret();
    addEntry(stMret, 32'h3020_0073, 0, 0, 0, 0, 0);
  endtask

  task automatic retireOne();
    addEntry(stRetire, 32'h13, 0, 0, 0, 0, 0);
  endtask

  task automatic fpFinish(input logic [4:0] flags);
    addEntry(stFp, 32'h13, 0, 0, 0, 0, flags);
  endtask

  task automatic idleCycle();
    addEntry(6'b0, 32'h13, 0, 0, 0, 0, 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic buildTable();
    logic [31:0] r;
    curTest = 1;
    rmw(adrMscratch, 3'b001, $random(seed));
    rmw(adrMscratch, 3'b010, $random(seed));
    rmw(adrMscratch, 3'b011, $random(seed));
    rmw(adrMscratch, 3'b101, 32'h15);
    rmw(adrMscratch, 3'b110, 32'h0A);
    rmw(adrMscratch, 3'b111, 32'h03);
    readCsr(adrMscratch);
    rmw(adrMtvec, 3'b001, $random(seed));
    rmw(adrMtvec, 3'b010, $random(seed));
    rmw(adrMtvec, 3'b011, $random(seed));
    rmw(adrMtvec, 3'b101, 32'h1F);
    rmw(adrMtvec, 3'b110, 32'h0C);
    rmw(adrMtvec, 3'b111, 32'h04);
    rmw(adrMtvec, 3'b001, $random(seed));
    readCsr(adrMtvec);
    curTest = 2;
    // Set MIE before the trap
    rmw(adrMstatus, 3'b110, 32'h8);
    r = $random(seed);
    raiseTrap(r | 32'h1, 32'h2, $random(seed));
    readCsr(adrMepc);
    readCsr(adrMcause);
    readCsr(adrMtval);
    readCsr(adrMstatus);
    curTest = 3;
    // MPP code 10 is not implemented and lands on U, so mret drops to U
    rmw(adrMstatus, 3'b001, 32'h1088);
    returnMret();
    readCsr(adrMscratch);
    rmw(adrMscratch, 3'b001, $random(seed));
    readCsr(adrMstatus);
    rmw(adrFrm, 3'b101, 32'h3);
    readCsr(adrFflags);
    raiseTrap($random(seed), 32'h8, 32'h0);
    readCsr(adrMscratch);
    readCsr(adrMstatus);
    curTest = 4;
    readCsr(12'h7C0);
    rmw(12'h7C0, 3'b001, $random(seed));
    rmw(adrMisa, 3'b001, $random(seed));
    readCsr(adrMisa);
    rmw(adrMhartid, 3'b001, $random(seed));
    readCsr(adrMhartid);
    curTest = 5;
    rmw(adrMinstret, 3'b001, $random(seed));
    repeat (5) retireOne();
    readCsr(adrMinstret);
    rmw(adrMcountinhibit, 3'b101, 32'h1);
    writeCsr(adrMcycle, $random(seed));
    readCsr(adrMcycle);
    idleCycle();
    readCsr(adrMcycle);
    rmw(adrMcountinhibit, 3'b111, 32'h1);
    idleCycle();
    idleCycle();
    readCsr(adrMcycle);
    readCsr(adrMcycleh);
    curTest = 6;
    fpFinish(5'b00101);
    fpFinish(5'b10000);
    readCsr(adrFflags);
    rmw(adrFcsr, 3'b001, $random(seed));
    readCsr(adrFrm);
    readCsr(adrFcsr);
    // Software write beats the flag update in the same cycle
    addEntry(stRead | stWrite | stFp, {adrFflags, 5'h02, 3'b101, 5'd1, 7'h73}, 0, 0, 0, 0,
             5'b11000);
    readCsr(adrFflags);
    fpFinish(5'b00001);
    readCsr(adrFcsr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////////////////////////

  task automatic driveEntry(input entryT e);
    {csrRead, csrWrite, trap, mret, retire, fpDone} = e.strobe;
    instr     = e.instr;
    srcA      = e.srcA;
    pc        = e.pc;
    cause     = e.cause;
    tval      = e.tval;
    setFflags = e.flags;
  endtask

  task automatic checkField(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      testErrs++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  initial begin
    entryT e;
    rstN = 1'b0;
    driveEntry('0);
    refPriv     = privM;
    {refMie, refMpie, refMpp} = '0;
    {refMtvec, refMscratch, refMepc, refMcause, refMtval, refInhibit} = '0;
    {refMcycle, refMinstret, refFflags, refFrm, refLastRead} = '0;
    buildTable();
    cycleLimit = stim.size() + 16 + 50;
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int i = 0; i < stim.size(); i++) begin
      e = stim[i];
      driveEntry(e);
      @(posedge clk);
      #1;
      checkField("readVal", readVal, e.expRead);
      checkField("illegalAccess", {31'b0, illegalAccess}, {31'b0, e.expIllegal});
      checkField("privilege", {30'b0, privilege}, {30'b0, e.expPriv});
      checkField("trapVector", trapVector, e.expVector);
      checkField("returnPc", returnPc, e.expReturn);
      checkField("frm", {29'b0, frm}, {29'b0, e.expFrm});
      // Last entry of a test closes it
      if (i == stim.size() - 1 || stim[i + 1].testId != e.testId) begin
        $display("Test %0d %s: %s", e.testId, testNames[e.testId],
                 (testErrs == 0) ? "passed" : "failed");
        if (testErrs == 0) testsPassed++;
        else testsFailed++;
        testErrs = 0;
      end
    end
    driveEntry('0);
    $display(
      "%0d tests, %0d passed, %0d failed, %0d checks, %0d mismatches, %0d assertion errors",
      testsPassed + testsFailed, testsPassed, testsFailed, checks, errors,
      i_csr.u_csrChecker.failCount);
    if (errors == 0 && i_csr.u_csrChecker.failCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Run limit from the table length
  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the stimulus loop did not finish", cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: build.f
csrPkg.sv
csrStatus.sv
csrMachine.sv
csrCounters.sv
csrFloat.sv
csr.sv
csr_checker.sv
csrTb.sv

// File: Bender.yml
package:
  name: csr

sources:
  - files:
      - csrPkg.sv
      - csrStatus.sv
      - csrMachine.sv
      - csrCounters.sv
      - csrFloat.sv
      - csr.sv
  - target: test
    files:
      - csr_checker.sv
      - csrTb.sv
